// ==== mm2s_config.svh ====
`ifndef MM2S_CONFIG_SVH
`define MM2S_CONFIG_SVH

////////////////////
// video side

// bits per pixel
`define MM2S_PIXEL_W 8
// width and height register bits
`define MM2S_DIM_W 12

////////////////////
// memory read side

`define MM2S_DATA_W 32
`define MM2S_ADDR_W 32
// max beats in one read burst
`define MM2S_BURST_LEN 16
// fifo words, also the reader's starting credits
`define MM2S_FIFO_DEPTH 32

`endif

// ==== rd_pkg.sv ====
`include "mm2s_config.svh"

package rd_pkg;

	typedef logic [`MM2S_ADDR_W-1:0] addr_t;
	typedef logic [`MM2S_DATA_W-1:0] data_t;
	// arlen, beats minus one
	typedef logic [7:0] burst_len_t;

	////////////////////
	// register map

	typedef logic [2:0] reg_addr_t;

	localparam reg_addr_t REG_CTRL   = 3'd0;
	localparam reg_addr_t REG_WIDTH  = 3'd1;
	localparam reg_addr_t REG_HEIGHT = 3'd2;
	localparam reg_addr_t REG_BASE   = 3'd3;
	localparam reg_addr_t REG_STATUS = 3'd4;

endpackage

// ==== vid_pkg.sv ====
`include "mm2s_config.svh"

package vid_pkg;

	// pixels carried by one bus word
	localparam int PIXELS_PER_WORD = `MM2S_DATA_W / `MM2S_PIXEL_W;

	typedef logic [`MM2S_PIXEL_W-1:0] pixel_t;
	typedef logic [`MM2S_DIM_W-1:0] dim_t;

	// fifo word layout
	// pixel 0 in the low byte, then sof, eol on top
	localparam int SOF_BIT = PIXELS_PER_WORD * `MM2S_PIXEL_W;
	localparam int EOL_BIT = SOF_BIT + 1;

	typedef logic [EOL_BIT:0] fifo_word_t;

	// shown in place of pixels of a misaligned line
	localparam pixel_t MARKER_PIXEL = 8'hA5;

endpackage

// ==== mm2s_regs.sv ====
module mm2s_regs
	import rd_pkg::*;
	import vid_pkg::*;
(
	input  logic      f2s_aclk,
	input  logic      resetn,
	input  logic      reg_wr,
	input  reg_addr_t reg_addr,
	input  data_t     reg_wdata,
	output data_t     reg_rdata,
	output logic      enable,
	output logic      soft_rst,
	output dim_t      img_width,
	output dim_t      img_height,
	output addr_t     base_addr,
	input  logic      line_err,
	input  logic      frame_done
);

	logic       err_sticky;
	logic [7:0] frame_cnt;

	// control, geometry, base address
	always_ff @(posedge f2s_aclk) begin
		if (!resetn) begin
			enable     <= 1'b0;
			soft_rst   <= 1'b0;
			img_width  <= '0;
			img_height <= '0;
			base_addr  <= '0;
		end else begin
			// ctrl bit 1 gives a single cycle pulse
			soft_rst <= reg_wr && (reg_addr == REG_CTRL) && reg_wdata[1];
			if (reg_wr) begin
				case (reg_addr)
					REG_CTRL:   enable     <= reg_wdata[0];
					REG_WIDTH:  img_width  <= dim_t'(reg_wdata);
					REG_HEIGHT: img_height <= dim_t'(reg_wdata);
					REG_BASE:   base_addr  <= addr_t'(reg_wdata);
					default: ;
				endcase
			end
		end
	end

	// status, cleared by soft reset only
	always_ff @(posedge f2s_aclk) begin
		if (!resetn || soft_rst) begin
			err_sticky <= 1'b0;
			frame_cnt  <= '0;
		end else begin
			if (line_err)
				err_sticky <= 1'b1;
			if (frame_done)
				frame_cnt <= frame_cnt + 8'd1;
		end
	end

	// readback
	always_comb begin
		case (reg_addr)
			REG_CTRL:   reg_rdata = {30'd0, soft_rst, enable};
			REG_WIDTH:  reg_rdata = data_t'(img_width);
			REG_HEIGHT: reg_rdata = data_t'(img_height);
			REG_BASE:   reg_rdata = data_t'(base_addr);
			REG_STATUS: reg_rdata = {16'd0, frame_cnt, 7'd0, err_sticky};
			default:    reg_rdata = '0;
		endcase
	end

endmodule

// ==== mm2s_burst_reader.sv ====
`include "mm2s_config.svh"

module mm2s_burst_reader
	import vid_pkg::*;
	import rd_pkg::*;
(
	input  logic       f2s_aclk,
	input  logic       resetn,
	input  logic       soft_rst,
	input  logic       enable,
	input  logic       fsync,
	input  dim_t       img_width,
	input  dim_t       img_height,
	input  addr_t      base_addr,
	output logic       frame_pulse,
	output logic       resetting,
	output logic       arvalid,
	output addr_t      araddr,
	output burst_len_t arlen,
	input  logic       arready,
	input  logic       rvalid,
	input  data_t      rdata,
	input  logic       rlast,
	output logic       rready,
	output logic       wr_en,
	output fifo_word_t wr_data,
	input  logic       credit_ret
);

	localparam int WORDS_W    = 2 * `MM2S_DIM_W;
	localparam int CRED_W     = $clog2(`MM2S_FIFO_DEPTH) + 1;
	localparam int BEAT_W     = $clog2(`MM2S_BURST_LEN) + 1;
	// bus words in one 4 KB page
	localparam int PAGE_WORDS = 4096 / (`MM2S_DATA_W / 8);
	localparam int PAGE_W     = $clog2(PAGE_WORDS) + 1;

	logic               busy;
	logic               drop;
	logic               outstanding;
	logic               sof_pend;
	addr_t              cur_addr;
	logic [WORDS_W-1:0] frame_px;
	logic [WORDS_W-1:0] words_left;
	logic [CRED_W-1:0]  credits;
	logic [CRED_W-1:0]  ar_beats;
	logic [BEAT_W-1:0]  beats;
	logic [PAGE_W-1:0]  to_bound;
	dim_t               words_per_line;
	dim_t               col;
	logic               start;
	logic               issue;
	logic               ar_hs;
	logic               r_hs;
	logic               w_eol;

	assign ar_hs    = arvalid && arready;
	assign r_hs     = rvalid && rready;
	// one burst in flight at a time
	assign rready   = outstanding;
	assign ar_beats = CRED_W'(arlen) + CRED_W'(1);
	assign frame_px = img_width * img_height;
	assign w_eol    = (col == words_per_line - 1'b1);

	assign start = fsync && enable && !busy && !drop && !soft_rst;
	assign issue = busy && !arvalid && !outstanding && (words_left != '0) &&
		(credits >= CRED_W'(beats)) && !soft_rst;

	////////////////////
	// burst sizing
	always_comb begin
		// words left before the next 4 KB line, addr bits 11:2
		to_bound = PAGE_W'(PAGE_WORDS) - PAGE_W'(cur_addr[11:2]);
		beats = BEAT_W'(`MM2S_BURST_LEN);
		// cut at frame end
		if (words_left < WORDS_W'(`MM2S_BURST_LEN))
			beats = BEAT_W'(words_left);
		// never cross the page
		if (to_bound < PAGE_W'(beats))
			beats = BEAT_W'(to_bound);
	end

	////////////////////
	// address channel
	always_ff @(posedge f2s_aclk) begin
		if (!resetn) begin
			arvalid     <= 1'b0;
			outstanding <= 1'b0;
		end else begin
			// arvalid held until accepted, even across soft reset
			if (ar_hs) begin
				arvalid     <= 1'b0;
				outstanding <= 1'b1;
			end else if (issue) begin
				arvalid <= 1'b1;
			end
			if (r_hs && rlast)
				outstanding <= 1'b0;
		end
	end

	always_ff @(posedge f2s_aclk) begin
		if (issue) begin
			araddr <= cur_addr;
			arlen  <= burst_len_t'(beats) - 8'd1;
		end
	end

	// frame pointer and line geometry
	always_ff @(posedge f2s_aclk) begin
		if (start) begin
			cur_addr       <= base_addr;
			words_per_line <= img_width >> 2;
		end else if (ar_hs) begin
			cur_addr <= cur_addr + (addr_t'(ar_beats) << 2);
		end
	end

	////////////////////
	// frame control and credits
	always_ff @(posedge f2s_aclk) begin
		if (!resetn) begin
			busy        <= 1'b0;
			drop        <= 1'b0;
			frame_pulse <= 1'b0;
			resetting   <= 1'b1;
			credits     <= CRED_W'(`MM2S_FIFO_DEPTH);
			words_left  <= '0;
			sof_pend    <= 1'b0;
			col         <= '0;
		end else if (soft_rst) begin
			busy        <= 1'b0;
			frame_pulse <= 1'b0;
			resetting   <= 1'b1;
			// fifo is flushed on the same cycle
			credits     <= CRED_W'(`MM2S_FIFO_DEPTH);
			words_left  <= '0;
			// a burst still on the bus is drained and thrown away
			drop        <= arvalid || outstanding;
		end else begin
			resetting   <= 1'b0;
			frame_pulse <= start;
			if (start) begin
				busy       <= 1'b1;
				words_left <= frame_px >> 2;
				sof_pend   <= 1'b1;
				col        <= '0;
			end else if (ar_hs && !drop) begin
				words_left <= words_left - WORDS_W'(ar_beats);
			end else if (busy && (words_left == '0) && !arvalid && !outstanding) begin
				busy <= 1'b0;
			end
			// taken at the handshake, returned per pop
			credits <= credits - ((ar_hs && !drop) ? ar_beats : '0) +
				CRED_W'(credit_ret);
			// word position within the line
			if (r_hs && !drop) begin
				sof_pend <= 1'b0;
				col      <= w_eol ? '0 : col + 1'b1;
			end
			if (drop && !arvalid && !outstanding)
				drop <= 1'b0;
		end
	end

	////////////////////
	// fifo write, one cycle after the beat
	always_ff @(posedge f2s_aclk) begin
		if (!resetn)
			wr_en <= 1'b0;
		else
			wr_en <= r_hs && !drop && !soft_rst;
	end

	always_ff @(posedge f2s_aclk) begin
		if (r_hs) begin
			wr_data[SOF_BIT-1:0] <= rdata;
			wr_data[SOF_BIT]     <= sof_pend;
			wr_data[EOL_BIT]     <= w_eol;
		end
	end

endmodule

// ==== mm2s_word_fifo.sv ====
`include "mm2s_config.svh"

module mm2s_word_fifo
	import vid_pkg::*;
(
	input  logic       f2s_aclk,
	input  logic       resetn,
	input  logic       flush,
	input  logic       wr_en,
	input  fifo_word_t wr_data,
	input  logic       rd_en,
	output fifo_word_t rd_data,
	output logic       empty,
	output logic       credit_ret
);

	localparam int DEPTH = `MM2S_FIFO_DEPTH;
	localparam int AW    = $clog2(DEPTH);

	fifo_word_t  mem [DEPTH];
	// extra top bit tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        push;
	logic        pop;

	// no full check, the credits keep the writer in bounds
	assign push       = wr_en && !flush;
	assign pop        = rd_en && !empty && !flush;
	assign empty      = (wr_ptr == rd_ptr);
	// one credit back per word popped
	assign credit_ret = pop;

	always_ff @(posedge f2s_aclk) begin
		if (!resetn || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge f2s_aclk) begin
		if (push)
			mem[wr_ptr[AW-1:0]] <= wr_data;
	end

	// registered read, data valid the cycle after rd_en
	always_ff @(posedge f2s_aclk) begin
		if (pop)
			rd_data <= mem[rd_ptr[AW-1:0]];
	end

endmodule

// ==== mm2s_stream_out.sv ====
module mm2s_stream_out
	import vid_pkg::*;
(
	input  logic       f2s_aclk,
	input  logic       resetn,
	input  logic       soft_rst,
	input  dim_t       img_width,
	input  dim_t       img_height,
	input  logic       empty,
	output logic       rd_en,
	input  fifo_word_t rd_data,
	output logic       tvalid,
	output pixel_t     tdata,
	output logic       tuser,
	output logic       tlast,
	input  logic       tready,
	output logic       line_err,
	output logic       frame_done
);

	localparam int PIX_W = $bits(pixel_t);
	localparam int CNT_W = $clog2(PIXELS_PER_WORD) + 1;

	// word waiting on the fifo output register
	logic                             hold_v;
	logic [PIXELS_PER_WORD*PIX_W-1:0] sh_data;
	logic                             sh_eol;
	logic [CNT_W-1:0]                 sh_cnt;
	logic                             bad_word;
	dim_t                             col;
	dim_t                             row;
	logic                             beat;
	logic                             last_px;
	logic                             last_row;
	logic                             load;
	logic                             word_eol;
	logic                             mismatch;

	assign tvalid  = (sh_cnt != '0);
	assign beat    = tvalid && tready;
	assign last_px = (sh_cnt == CNT_W'(1));
	// refill as the last pixel of a word leaves
	assign load    = hold_v && (!tvalid || (last_px && beat));
	assign rd_en   = !empty && (!hold_v || load) && !soft_rst;

	////////////////////
	// markers from own counters, live geometry
	assign tuser    = (col == '0) && (row == '0);
	assign tlast    = (col >= img_width - 1'b1);
	assign last_row = (row >= img_height - 1'b1);

	// word says line ends at its last pixel
	assign word_eol   = sh_eol && last_px;
	assign mismatch   = tvalid && (word_eol != tlast);
	assign tdata      = (bad_word || mismatch) ? MARKER_PIXEL : sh_data[PIX_W-1:0];
	assign line_err   = beat && mismatch;
	assign frame_done = beat && tlast && last_row;

	always_ff @(posedge f2s_aclk) begin
		if (!resetn || soft_rst)
			hold_v <= 1'b0;
		else if (rd_en)
			hold_v <= 1'b1;
		else if (load)
			hold_v <= 1'b0;
	end

	// pixels left in the shift register
	always_ff @(posedge f2s_aclk) begin
		if (!resetn || soft_rst) begin
			sh_cnt   <= '0;
			bad_word <= 1'b0;
		end else if (load) begin
			sh_cnt   <= CNT_W'(PIXELS_PER_WORD);
			bad_word <= 1'b0;
		end else if (beat) begin
			sh_cnt   <= sh_cnt - 1'b1;
			// rest of the word stays marked
			bad_word <= bad_word || mismatch;
		end
	end

	always_ff @(posedge f2s_aclk) begin
		if (load) begin
			sh_data <= rd_data[PIXELS_PER_WORD*PIX_W-1:0];
			sh_eol  <= rd_data[EOL_BIT];
		end else if (beat) begin
			// next pixel into the low byte
			sh_data <= sh_data >> PIX_W;
		end
	end

	////////////////////
	// column and row
	always_ff @(posedge f2s_aclk) begin
		if (!resetn || soft_rst) begin
			col <= '0;
			row <= '0;
		end else if (beat) begin
			if (tlast) begin
				col <= '0;
				row <= last_row ? '0 : row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

endmodule

// ==== mm2s_top.sv ====
module mm2s_top
	import vid_pkg::*;
	import rd_pkg::*;
(
	input  logic       f2s_aclk,
	input  logic       resetn,
	input  logic       fsync,
	// register port
	input  logic       reg_wr,
	input  reg_addr_t  reg_addr,
	input  data_t      reg_wdata,
	output data_t      reg_rdata,
	// read bus
	output logic       arvalid,
	output addr_t      araddr,
	output burst_len_t arlen,
	input  logic       arready,
	input  logic       rvalid,
	input  data_t      rdata,
	input  logic       rlast,
	output logic       rready,
	output logic       resetting,
	output logic       frame_pulse,
	// video stream
	output logic       tvalid,
	output pixel_t     tdata,
	output logic       tuser,
	output logic       tlast,
	input  logic       tready
);

	logic       enable;
	logic       soft_rst;
	dim_t       img_width;
	dim_t       img_height;
	addr_t      base_addr;
	logic       line_err;
	logic       frame_done;
	logic       wr_en;
	fifo_word_t wr_data;
	logic       rd_en;
	fifo_word_t rd_data;
	logic       empty;
	logic       credit_ret;

	mm2s_regs i_regs (
		.f2s_aclk, .resetn, .reg_wr, .reg_addr, .reg_wdata, .reg_rdata,
		.enable, .soft_rst, .img_width, .img_height, .base_addr,
		.line_err, .frame_done
	);

	mm2s_burst_reader i_reader (
		.f2s_aclk, .resetn, .soft_rst, .enable, .fsync,
		.img_width, .img_height, .base_addr, .frame_pulse, .resetting,
		.arvalid, .araddr, .arlen, .arready, .rvalid, .rdata, .rlast, .rready,
		.wr_en, .wr_data, .credit_ret
	);

	// soft reset empties the fifo
	mm2s_word_fifo i_fifo (
		.f2s_aclk, .resetn, .flush(soft_rst), .wr_en, .wr_data,
		.rd_en, .rd_data, .empty, .credit_ret
	);

	mm2s_stream_out i_stream (
		.f2s_aclk, .resetn, .soft_rst, .img_width, .img_height,
		.empty, .rd_en, .rd_data, .tvalid, .tdata, .tuser, .tlast, .tready,
		.line_err, .frame_done
	);

endmodule

// ==== mm2s_mem_model.sv ====
module mm2s_mem_model
	import rd_pkg::*;
#(
	parameter int SEED = 29
) (
	input  logic       f2s_aclk,
	input  logic       resetn,
	input  logic       arvalid,
	input  addr_t      araddr,
	input  burst_len_t arlen,
	output logic       arready,
	output logic       rvalid,
	output data_t      rdata,
	output logic       rlast,
	input  logic       rready
);
	timeunit 1ns;
	timeprecision 1ps;

	// one byte per address
	function automatic logic [7:0] byte_at(input addr_t a);
		return a[7:0] * 8'd7 + 8'd3;
	endfunction

	// lowest address in the low byte
	function automatic data_t word_at(input addr_t a);
		data_t w;
		for (int i = 0; i < 4; i++)
			w[8*i +: 8] = byte_at(a + addr_t'(i));
		return w;
	endfunction

	// single process, so the seed covers every gap
	initial begin
		addr_t addr;
		int    left;
		int    gap;
		bit    in_burst;
		bit    showing;
		void'($urandom(SEED));
		arready  = 1'b0;
		rvalid   = 1'b0;
		rlast    = 1'b0;
		rdata    = '0;
		addr     = '0;
		left     = 0;
		gap      = 0;
		in_burst = 1'b0;
		showing  = 1'b0;
		forever begin
			@(posedge f2s_aclk);
			if (!resetn) begin
				arready <= 1'b0;
				rvalid  <= 1'b0;
				rlast   <= 1'b0;
				in_burst = 1'b0;
				showing  = 1'b0;
				gap      = 0;
			end else if (!in_burst) begin
				////////////////////
				// address phase
				if (arvalid && arready) begin
					arready <= 1'b0;
					addr     = araddr;
					left     = int'(arlen) + 1;
					in_burst = 1'b1;
					gap      = $urandom_range(2, 0);
				end else if (arvalid) begin
					// random wait before arready
					if (gap > 0)
						gap--;
					else
						arready <= 1'b1;
				end
			end else begin
				////////////////////
				// data phase
				if (showing && rready) begin
					addr    = addr + 32'd4;
					left    = left - 1;
					showing = 1'b0;
					gap     = $urandom_range(2, 0);
				end
				if (!showing) begin
					if (left == 0) begin
						in_burst = 1'b0;
						// gap before the next arready
						gap      = $urandom_range(3, 0);
					end else if (gap > 0) begin
						gap--;
					end else begin
						showing = 1'b1;
					end
				end
				rvalid <= showing;
				rdata  <= word_at(addr);
				rlast  <= showing && (left == 1);
			end
		end
	end

endmodule

// ==== mm2s_asserts.sv ====
`include "mm2s_config.svh"

module mm2s_asserts
	import vid_pkg::*;
	import rd_pkg::*;
(
	input logic       f2s_aclk,
	input logic       resetn,
	input logic       soft_rst,
	input logic       arvalid,
	input logic       arready,
	input addr_t      araddr,
	input burst_len_t arlen,
	input logic       wr_en,
	input logic       credit_ret,
	input logic       tvalid,
	input logic       tready,
	input pixel_t     tdata,
	input logic       tuser,
	input logic       tlast
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DEPTH   = `MM2S_FIFO_DEPTH;
	localparam int LEVEL_W = $clog2(DEPTH) + 2;

	// read by the testbench top
	int unsigned        fail_cnt = 0;
	logic [LEVEL_W-1:0] level;
	// a read request was accepted since reset
	logic               req_seen;

	// fifo fill level, push minus pop
	always_ff @(posedge f2s_aclk) begin
		if (!resetn || soft_rst)
			level <= '0;
		else
			level <= level + LEVEL_W'(wr_en) - LEVEL_W'(credit_ret);
	end

	always_ff @(posedge f2s_aclk) begin
		if (!resetn)
			req_seen <= 1'b0;
		else if (arvalid && arready)
			req_seen <= 1'b1;
	end

	////////////////////
	// read address channel
	ar_hold: assert property (@(posedge f2s_aclk) disable iff (!resetn)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
		else begin
			$error("read request changed or dropped before arready");
			fail_cnt++;
		end

	////////////////////
	// stalled stream beat
	t_hold: assert property (@(posedge f2s_aclk) disable iff (!resetn || soft_rst)
		tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tuser) && $stable(tlast))
		else begin
			$error("stream beat changed while stalled");
			fail_cnt++;
		end

	// a push into a full fifo needs a pop on the same cycle
	no_overflow: assert property (@(posedge f2s_aclk) disable iff (!resetn || soft_rst)
		!(wr_en && !credit_ret && (level >= LEVEL_W'(DEPTH))))
		else begin
			$error("fifo written while full");
			fail_cnt++;
		end

	// no fifo write until the first read request after reset
	wr_after_rst: assert property (@(posedge f2s_aclk) disable iff (!resetn)
		!req_seen |-> !wr_en)
		else begin
			$error("fifo written before any read request after reset");
			fail_cnt++;
		end

endmodule

// ==== tb_mm2s.sv ====
module tb_mm2s
	import rd_pkg::*;
	import vid_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_TESTS = 5;

	////////////////////
	// stimulus table, one column per test
	// rdy is the tready duty pattern, one bit per cycle
	int unsigned tbl_w       [NUM_TESTS] = '{8, 64, 32, 16, 16};
	int unsigned tbl_h       [NUM_TESTS] = '{4, 6, 8, 4, 4};
	logic [31:0] tbl_base    [NUM_TESTS] = '{32'h1000, 32'h0FE0, 32'h2004, 32'h3000, 32'h4010};
	logic [31:0] tbl_rdy     [NUM_TESTS] = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h96D3_4B6A,
		32'hFFFF_FFFF, 32'hF7FB_EFDF};
	bit          tbl_rewrite [NUM_TESTS] = '{0, 0, 0, 1, 0};
	bit          tbl_err     [NUM_TESTS] = '{0, 0, 0, 1, 0};
	int unsigned tbl_frames  [NUM_TESTS] = '{1, 1, 1, 1, 2};

	logic       f2s_aclk = 1'b0;
	logic       resetn;
	logic       fsync;
	logic       reg_wr;
	reg_addr_t  reg_addr;
	data_t      reg_wdata;
	data_t      reg_rdata;
	logic       arvalid;
	addr_t      araddr;
	burst_len_t arlen;
	logic       arready;
	logic       rvalid;
	data_t      rdata;
	logic       rlast;
	logic       rready;
	logic       resetting;
	logic       frame_pulse;
	logic       tvalid;
	pixel_t     tdata;
	logic       tuser;
	logic       tlast;
	logic       tready;
	int         err_cnt = 0;

	always #10 f2s_aclk = ~f2s_aclk;

	mm2s_top i_mm2s_top (
		.f2s_aclk, .resetn, .fsync, .reg_wr, .reg_addr, .reg_wdata, .reg_rdata,
		.arvalid, .araddr, .arlen, .arready, .rvalid, .rdata, .rlast, .rready,
		.resetting, .frame_pulse, .tvalid, .tdata, .tuser, .tlast, .tready
	);

	mm2s_mem_model #(.SEED(29)) i_mem (
		.f2s_aclk, .resetn, .arvalid, .araddr, .arlen, .arready,
		.rvalid, .rdata, .rlast, .rready
	);

	bind mm2s_top mm2s_asserts i_asserts (.*);

	// memory contents, low address byte times 7 plus 3
	function automatic pixel_t model_byte(input addr_t a);
		return pixel_t'(a[7:0] * 8'd7 + 8'd3);
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		$display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
		err_cnt++;
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic write_reg(input reg_addr_t a, input data_t d);
		@(posedge f2s_aclk);
		reg_wr    <= 1'b1;
		reg_addr  <= a;
		reg_wdata <= d;
		@(posedge f2s_aclk);
		reg_wr <= 1'b0;
	endtask

	// readback is combinational, sampled mid cycle
	task automatic read_reg(input reg_addr_t a, output data_t d);
		@(posedge f2s_aclk);
		reg_wr   <= 1'b0;
		reg_addr <= a;
		@(negedge f2s_aclk);
		d = reg_rdata;
	endtask

	// frame_pulse due one cycle after the fsync edge
	task automatic pulse_fsync(output bit accepted);
		@(posedge f2s_aclk);
		fsync <= 1'b1;
		@(posedge f2s_aclk);
		fsync <= 1'b0;
		@(negedge f2s_aclk);
		accepted = frame_pulse;
		assert (accepted) else report_failure("fsync not accepted, frame_pulse stayed low");
	endtask

	////////////////////
	// collect one frame until frame_done
	task automatic run_frame(input int t, output int n_pix, output int n_user,
		output int n_mark);
		int unsigned w;
		int unsigned h;
		int unsigned cyc;
		bit          wrote;
		bit          done;
		pixel_t      exp;
		w      = tbl_w[t];
		h      = tbl_h[t];
		cyc    = 0;
		wrote  = 1'b0;
		done   = 1'b0;
		n_pix  = 0;
		n_user = 0;
		n_mark = 0;
		while (!done) begin
			@(posedge f2s_aclk);
			tready <= tbl_rdy[t][cyc % 32];
			cyc++;
			// width change a third into the frame
			if (tbl_rewrite[t] && !wrote && (n_pix >= w * h / 3)) begin
				reg_wr    <= 1'b1;
				reg_addr  <= REG_WIDTH;
				reg_wdata <= data_t'(w - 4);
				wrote = 1'b1;
			end else begin
				reg_wr <= 1'b0;
			end
			@(negedge f2s_aclk);
			if (arvalid && arready)
				assert (int'(araddr[11:0]) + (int'(arlen) + 1) * 4 <= 4096)
				else report_failure("read burst crosses a 4 KB boundary");
			// read data is never refused during a burst
			assert (!rvalid || rready) else report_failure("rready low while read data offered");
			if (tvalid && tready) begin
				exp = model_byte(tbl_base[t] + addr_t'(n_pix));
				if (tuser)
					n_user++;
				if (tbl_rewrite[t]) begin
					if (tdata == MARKER_PIXEL && exp != MARKER_PIXEL)
						n_mark++;
					assert (tdata == exp || tdata == MARKER_PIXEL)
					else report_mismatch($sformatf("test %0d pixel %0d", t + 1, n_pix), tdata, exp);
				end else begin
					assert (tdata == exp)
					else report_mismatch($sformatf("test %0d pixel %0d", t + 1, n_pix), tdata, exp);
					assert (tuser == (n_pix == 0))
					else report_mismatch($sformatf("test %0d tuser at %0d", t + 1, n_pix), tuser,
						n_pix == 0);
					assert (tlast == (n_pix % w == w - 1))
					else report_mismatch($sformatf("test %0d tlast at %0d", t + 1, n_pix), tlast,
						n_pix % w == w - 1);
				end
				n_pix++;
				done = i_mm2s_top.frame_done;
			end
		end
	endtask

	// soft reset clears status and the stream
	task automatic check_soft_reset();
		data_t status;
		bit    seen;
		seen = 1'b0;
		write_reg(REG_CTRL, 32'd3);
		for (int i = 0; i < 6; i++) begin
			@(negedge f2s_aclk);
			seen |= resetting;
		end
		assert (seen) else report_failure("resetting did not go high after soft reset");
		for (int i = 0; i < 8; i++) begin
			@(posedge f2s_aclk);
			tready <= 1'b1;
			@(negedge f2s_aclk);
			assert (!tvalid) else report_failure("tvalid high after soft reset");
		end
		read_reg(REG_STATUS, status);
		assert (status == '0) else report_mismatch("STATUS after soft reset", status, 0);
	endtask

	////////////////////
	// watchdog, four cycles per pixel plus slack
	initial begin
		int unsigned limit;
		limit = 2000;
		for (int i = 0; i < NUM_TESTS; i++)
			limit += tbl_w[i] * tbl_h[i] * tbl_frames[i] * 4;
		repeat (limit) @(posedge f2s_aclk);
		$display("timeout: run did not finish within %0d cycles", limit);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		data_t      status;
		logic [7:0] count_before;
		int         n_pix;
		int         n_user;
		int         n_mark;
		int         test_err;
		int         passed;
		int         asrt_fail;
		bit         accepted;
		resetn    = 1'b0;
		fsync     = 1'b0;
		reg_wr    = 1'b0;
		reg_addr  = REG_CTRL;
		reg_wdata = '0;
		tready    = 1'b0;
		passed    = 0;
		repeat (5) @(posedge f2s_aclk);
		resetn <= 1'b1;

		for (int t = 0; t < NUM_TESTS; t++) begin
			test_err = err_cnt;
			n_mark   = 0;
			write_reg(REG_WIDTH, data_t'(tbl_w[t]));
			write_reg(REG_HEIGHT, data_t'(tbl_h[t]));
			write_reg(REG_BASE, tbl_base[t]);
			write_reg(REG_CTRL, 32'd1);
			for (int f = 0; f < tbl_frames[t]; f++) begin
				read_reg(REG_STATUS, status);
				count_before = status[15:8];
				pulse_fsync(accepted);
				if (accepted) begin
					run_frame(t, n_pix, n_user, n_mark);
					if (!tbl_rewrite[t])
						assert (n_pix == tbl_w[t] * tbl_h[t])
						else report_mismatch("pixels in frame", n_pix, tbl_w[t] * tbl_h[t]);
					assert (n_user == 1) else report_mismatch("tuser beats in frame", n_user, 1);
				end
				read_reg(REG_STATUS, status);
				assert (status[15:8] == count_before + 8'd1)
				else report_mismatch("frame count", status[15:8], count_before + 8'd1);
			end
			assert (status[0] == tbl_err[t])
			else report_mismatch("STATUS error bit", status[0], tbl_err[t]);
			if (tbl_rewrite[t]) begin
				assert (n_mark > 0) else report_failure("no marker pixel after the width change");
				check_soft_reset();
			end
			if (err_cnt == test_err)
				passed++;
			$display("test %0d: %0dx%0d, %0d frame(s), %0d errors", t + 1, tbl_w[t], tbl_h[t],
				tbl_frames[t], err_cnt - test_err);
		end

		asrt_fail = i_mm2s_top.i_asserts.fail_cnt;
		$display("summary: %0d tests, %0d passed, %0d check errors, %0d assertion failures",
			NUM_TESTS, passed, err_cnt, asrt_fail);
		if (err_cnt == 0 && asrt_fail == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
rd_pkg.sv
vid_pkg.sv
mm2s_regs.sv
mm2s_burst_reader.sv
mm2s_word_fifo.sv
mm2s_stream_out.sv
mm2s_top.sv
mm2s_mem_model.sv
mm2s_asserts.sv
tb_mm2s.sv

// ==== Bender.yml ====
package:
  name: mm2s_video_read

export_include_dirs:
  - .

sources:
  # design
  - include_dirs:
      - .
    files:
      - rd_pkg.sv
      - vid_pkg.sv
      - mm2s_regs.sv
      - mm2s_burst_reader.sv
      - mm2s_word_fifo.sv
      - mm2s_stream_out.sv
      - mm2s_top.sv
  # testbench
  - target: test
    include_dirs:
      - .
    files:
      - mm2s_mem_model.sv
      - mm2s_asserts.sv
      - tb_mm2s.sv
